/* hdl/rv32_pkg.sv */
package rv32_pkg;

    // **************************************************
    // Widths
    // **************************************************

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;

    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  alu_src_t;
    typedef logic [1:0]  branch_op_t;
    typedef logic [1:0]  csr_op_t;
    typedef logic [1:0]  mem_width_t;

    // **************************************************
    // Operation codes
    // **************************************************

    // ALU functions follow the funct3 encoding of the base ISA.
    localparam alu_op_t alu_add  = 3'b000;
    localparam alu_op_t alu_sll  = 3'b001;
    localparam alu_op_t alu_slt  = 3'b010;
    localparam alu_op_t alu_sltu = 3'b011;
    localparam alu_op_t alu_xor  = 3'b100;
    localparam alu_op_t alu_srl  = 3'b101;
    localparam alu_op_t alu_or   = 3'b110;
    localparam alu_op_t alu_and  = 3'b111;

    localparam alu_src_t src1_rs1  = 2'b00;
    localparam alu_src_t src1_pc   = 2'b01;
    localparam alu_src_t src1_zero = 2'b10;

    localparam alu_src_t src2_rs2  = 2'b00;
    localparam alu_src_t src2_imm  = 2'b01;
    localparam alu_src_t src2_four = 2'b10;

    localparam branch_op_t branch_never   = 2'b00;
    localparam branch_op_t branch_zero    = 2'b01;
    localparam branch_op_t branch_nonzero = 2'b10;
    localparam branch_op_t branch_always  = 2'b11;

    localparam csr_op_t csr_rw = 2'b01;
    localparam csr_op_t csr_rs = 2'b10;
    localparam csr_op_t csr_rc = 2'b11;

    // **************************************************
    // CSR addresses
    // **************************************************

    localparam csr_addr_t csr_cycle    = 12'hc00;
    localparam csr_addr_t csr_cycleh   = 12'hc80;
    localparam csr_addr_t csr_instret  = 12'hc02;
    localparam csr_addr_t csr_instreth = 12'hc82;
    localparam csr_addr_t csr_mscratch = 12'h340;

endpackage

/* hdl/rv32_alu.sv */
`timescale 1ns/10ps

module rv32_alu (
    input  rv32_pkg::alu_op_t  op,
    input  logic               sub_sra,
    input  rv32_pkg::alu_src_t src1,
    input  rv32_pkg::alu_src_t src2,
    input  rv32_pkg::word_t    pc,
    input  rv32_pkg::word_t    rs1_value,
    input  rv32_pkg::word_t    rs2_value,
    input  rv32_pkg::word_t    imm_value,
    output rv32_pkg::word_t    result
);
    rv32_pkg::word_t a;
    rv32_pkg::word_t b;
    logic [4:0]      shamt;

    always_comb begin
        case (src1)
            rv32_pkg::src1_rs1:  a = rs1_value;
            rv32_pkg::src1_pc:   a = pc;
            rv32_pkg::src1_zero: a = '0;
            default:             a = '0;
        endcase
    end

    always_comb begin
        case (src2)
            rv32_pkg::src2_rs2:  b = rs2_value;
            rv32_pkg::src2_imm:  b = imm_value;
            rv32_pkg::src2_four: b = 32'd4;
            default:             b = '0;
        endcase
    end

    // Only the low five bits count as a shift amount
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv32_pkg::alu_add: begin
                if (sub_sra)
                    result = a - b;
                else
                    result = a + b;
            end
            rv32_pkg::alu_sll:  result = a << shamt;
            rv32_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            rv32_pkg::alu_sltu: result = {31'b0, a < b};
            rv32_pkg::alu_xor:  result = a ^ b;
            rv32_pkg::alu_srl: begin
                if (sub_sra)
                    result = $signed(a) >>> shamt;
                else
                    result = a >> shamt;
            end
            rv32_pkg::alu_or:   result = a | b;
            rv32_pkg::alu_and:  result = a & b;
            default:            result = '0;
        endcase
    end

endmodule

/* hdl/rv32_csrs.sv */
`timescale 1ns/10ps

module rv32_csrs (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                flush,
    input  logic                read,
    input  logic                write,
    input  rv32_pkg::csr_op_t   write_op,
    input  logic                src,
    input  logic                retire,
    input  rv32_pkg::word_t     rs1_value,
    input  rv32_pkg::word_t     imm_value,
    input  rv32_pkg::csr_addr_t csr,
    output rv32_pkg::word_t     read_value,
    output rv32_pkg::counter_t  cycle
);
    rv32_pkg::counter_t instret;
    rv32_pkg::word_t    mscratch;
    rv32_pkg::word_t    current;
    rv32_pkg::word_t    write_value;
    rv32_pkg::word_t    next_mscratch;
    logic               mscratch_write;

    // **************************************************
    // Read path
    // **************************************************

    always_comb begin
        case (csr)
            rv32_pkg::csr_cycle:    current = cycle[31:0];
            rv32_pkg::csr_cycleh:   current = cycle[63:32];
            rv32_pkg::csr_instret:  current = instret[31:0];
            rv32_pkg::csr_instreth: current = instret[63:32];
            rv32_pkg::csr_mscratch: current = mscratch;
            default:                current = '0;
        endcase
    end

    assign read_value = read ? current : '0;

    // **************************************************
    // Write path
    // **************************************************

    // The immediate form carries a 5-bit unsigned value in the rs1 field.
    assign write_value = src ? {27'b0, imm_value[4:0]} : rs1_value;

    always_comb begin
        case (write_op)
            rv32_pkg::csr_rw: next_mscratch = write_value;
            rv32_pkg::csr_rs: next_mscratch = mscratch | write_value;
            rv32_pkg::csr_rc: next_mscratch = mscratch & ~write_value;
            default:          next_mscratch = mscratch;
        endcase
    end

    // The counters are read-only, so only mscratch can change.
    assign mscratch_write = write && !stall && !flush && csr == rv32_pkg::csr_mscratch;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle    <= '0;
            instret  <= '0;
            mscratch <= '0;
        end else begin
            // Cycle counts every edge, stalled or not.
            cycle <= cycle + 1'b1;

            if (retire)
                instret <= instret + 1'b1;

            if (mscratch_write)
                mscratch <= next_mscratch;
        end
    end

    // An instruction needs at least one cycle per retirement.
    instret_le_cycle: assert property (
        @(posedge clk) disable iff (reset) instret <= cycle
    ) else $error("instret %0d ahead of cycle %0d", instret, cycle);

endmodule

/* hdl/rv32_execute.sv */
`timescale 1ns/10ps

module rv32_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  mem_flush,
    input  logic                  writeback_flush,
    input  logic                  predicted_taken,
    input  logic                  valid,
    input  rv32_pkg::reg_addr_t   rs1,
    input  rv32_pkg::reg_addr_t   rs2,
    input  rv32_pkg::alu_op_t     alu_op,
    input  logic                  alu_sub_sra,
    input  rv32_pkg::alu_src_t    alu_src1,
    input  rv32_pkg::alu_src_t    alu_src2,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  rv32_pkg::mem_width_t  mem_width,
    input  logic                  mem_zero_extend,
    input  logic                  mem_fence,
    input  logic                  csr_read,
    input  logic                  csr_write,
    input  rv32_pkg::csr_op_t     csr_write_op,
    input  logic                  csr_src,
    input  rv32_pkg::branch_op_t  branch_op,
    input  logic                  branch_pc_src,
    input  rv32_pkg::reg_addr_t   rd,
    input  logic                  rd_write,
    input  rv32_pkg::word_t       pc,
    input  rv32_pkg::word_t       rs1_value,
    input  rv32_pkg::word_t       rs2_value,
    input  rv32_pkg::word_t       imm_value,
    input  rv32_pkg::csr_addr_t   csr,
    input  rv32_pkg::reg_addr_t   wb_rd,
    input  logic                  wb_rd_write,
    input  rv32_pkg::word_t       wb_value,
    input  logic                  retire,
    output logic                  predicted_taken_out,
    output logic                  valid_out,
    output logic                  mem_read_out,
    output logic                  mem_write_out,
    output rv32_pkg::mem_width_t  mem_width_out,
    output logic                  mem_zero_extend_out,
    output logic                  mem_fence_out,
    output rv32_pkg::branch_op_t  branch_op_out,
    output rv32_pkg::reg_addr_t   rd_out,
    output logic                  rd_write_out,
    output rv32_pkg::word_t       result,
    output rv32_pkg::word_t       rs2_value_out,
    output rv32_pkg::word_t       branch_pc,
    output rv32_pkg::counter_t    cycle
);
    logic            rs1_from_ex;
    logic            rs1_from_wb;
    logic            rs2_from_ex;
    logic            rs2_from_wb;
    rv32_pkg::word_t rs1_bypassed;
    rv32_pkg::word_t rs2_bypassed;
    rv32_pkg::word_t alu_result;
    rv32_pkg::word_t csr_value;
    rv32_pkg::word_t branch_target;

    // **************************************************
    // Bypass
    // **************************************************

    // The newer writer sits in our own output register, so it wins.
    assign rs1_from_ex = rd_write_out && !mem_flush && rd_out == rs1 && rs1 != '0;
    assign rs1_from_wb = wb_rd_write && !writeback_flush && wb_rd == rs1 && rs1 != '0;
    assign rs2_from_ex = rd_write_out && !mem_flush && rd_out == rs2 && rs2 != '0;
    assign rs2_from_wb = wb_rd_write && !writeback_flush && wb_rd == rs2 && rs2 != '0;

    assign rs1_bypassed = rs1_from_ex ? result : (rs1_from_wb ? wb_value : rs1_value);
    assign rs2_bypassed = rs2_from_ex ? result : (rs2_from_wb ? wb_value : rs2_value);

    rv32_alu alu (
        .op        (alu_op),
        .sub_sra   (alu_sub_sra),
        .src1      (alu_src1),
        .src2      (alu_src2),
        .pc        (pc),
        .rs1_value (rs1_bypassed),
        .rs2_value (rs2_bypassed),
        .imm_value (imm_value),
        .result    (alu_result)
    );

    rv32_csrs csrs (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .read       (csr_read),
        .write      (csr_write && valid),
        .write_op   (csr_write_op),
        .src        (csr_src),
        .retire     (retire),
        .rs1_value  (rs1_bypassed),
        .imm_value  (imm_value),
        .csr        (csr),
        .read_value (csr_value),
        .cycle      (cycle)
    );

    // A predicted-taken branch carries the fall-through address for recovery.
    always_comb begin
        if (predicted_taken)
            branch_target = pc + 32'd4;
        else if (branch_pc_src)
            branch_target = (rs1_bypassed + imm_value) & ~32'd1;
        else
            branch_target = pc + imm_value;
    end

    // **************************************************
    // Pipeline register
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            predicted_taken_out <= 1'b0;
            valid_out           <= 1'b0;
            mem_read_out        <= 1'b0;
            mem_write_out       <= 1'b0;
            branch_op_out       <= rv32_pkg::branch_never;
            rd_write_out        <= 1'b0;
        end else if (!stall) begin
            if (flush) begin
                predicted_taken_out <= 1'b0;
                valid_out           <= 1'b0;
                mem_read_out        <= 1'b0;
                mem_write_out       <= 1'b0;
                branch_op_out       <= rv32_pkg::branch_never;
                rd_write_out        <= 1'b0;
            end else begin
                predicted_taken_out <= predicted_taken;
                valid_out           <= valid;
                mem_read_out        <= mem_read;
                mem_write_out       <= mem_write;
                branch_op_out       <= branch_op;
                rd_write_out        <= rd_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_width_out       <= mem_width;
            mem_zero_extend_out <= mem_zero_extend;
            mem_fence_out       <= mem_fence;
            rd_out              <= rd;
            result              <= csr_read ? csr_value : alu_result;
            rs2_value_out       <= rs2_bypassed;
            branch_pc           <= branch_target;
        end
    end

    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (reset) flush && !stall |=> !valid_out
    ) else $error("valid_out set after a flush");

    // x0 must always reach the ALU as the register file value.
    no_zero_bypass: assert property (
        @(posedge clk) disable iff (reset)
        (rs1 == '0 |-> rs1_bypassed == rs1_value) and (rs2 == '0 |-> rs2_bypassed == rs2_value)
    ) else $error("register 0 was bypassed");

endmodule

/* hdl/rv32_writeback_latch.sv */
`timescale 1ns/10ps

module rv32_writeback_latch (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                writeback_flush,
    input  logic                valid,
    input  rv32_pkg::reg_addr_t rd,
    input  logic                rd_write,
    input  rv32_pkg::word_t     result,
    output logic                wb_valid,
    output rv32_pkg::reg_addr_t wb_rd,
    output logic                wb_rd_write,
    output rv32_pkg::word_t     wb_value,
    output logic                retire
);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid    <= 1'b0;
            wb_rd_write <= 1'b0;
        end else if (!stall) begin
            wb_valid    <= valid;
            wb_rd_write <= rd_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd    <= rd;
            wb_value <= result;
        end
    end

    // An instruction retires once, on the edge that moves it out of this stage.
    assign retire = wb_valid && !writeback_flush && !stall;

endmodule

/* hdl/rv32_exec_top.sv */
`timescale 1ns/10ps

module rv32_exec_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  mem_flush,
    input  logic                  writeback_flush,
    input  logic                  predicted_taken,
    input  logic                  valid,
    input  rv32_pkg::reg_addr_t   rs1,
    input  rv32_pkg::reg_addr_t   rs2,
    input  rv32_pkg::alu_op_t     alu_op,
    input  logic                  alu_sub_sra,
    input  rv32_pkg::alu_src_t    alu_src1,
    input  rv32_pkg::alu_src_t    alu_src2,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  rv32_pkg::mem_width_t  mem_width,
    input  logic                  mem_zero_extend,
    input  logic                  mem_fence,
    input  logic                  csr_read,
    input  logic                  csr_write,
    input  rv32_pkg::csr_op_t     csr_write_op,
    input  logic                  csr_src,
    input  rv32_pkg::branch_op_t  branch_op,
    input  logic                  branch_pc_src,
    input  rv32_pkg::reg_addr_t   rd,
    input  logic                  rd_write,
    input  rv32_pkg::word_t       pc,
    input  rv32_pkg::word_t       rs1_value,
    input  rv32_pkg::word_t       rs2_value,
    input  rv32_pkg::word_t       imm_value,
    input  rv32_pkg::csr_addr_t   csr,
    output logic                  predicted_taken_out,
    output logic                  valid_out,
    output logic                  mem_read_out,
    output logic                  mem_write_out,
    output rv32_pkg::mem_width_t  mem_width_out,
    output logic                  mem_zero_extend_out,
    output logic                  mem_fence_out,
    output rv32_pkg::branch_op_t  branch_op_out,
    output rv32_pkg::reg_addr_t   rd_out,
    output logic                  rd_write_out,
    output rv32_pkg::word_t       result,
    output rv32_pkg::word_t       rs2_value_out,
    output rv32_pkg::word_t       branch_pc,
    output rv32_pkg::counter_t    cycle,
    output logic                  wb_valid,
    output rv32_pkg::reg_addr_t   wb_rd,
    output logic                  wb_rd_write,
    output rv32_pkg::word_t       wb_value
);
    logic retire;

    // All execute ports share their names with the top level.
    rv32_execute execute (.*);

    rv32_writeback_latch writeback (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .writeback_flush (writeback_flush),
        .valid           (valid_out),
        .rd              (rd_out),
        .rd_write        (rd_write_out),
        .result          (result),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_rd_write     (wb_rd_write),
        .wb_value        (wb_value),
        .retire          (retire)
    );

endmodule

/* bench/rv32_exec_tb.sv */
`timescale 1ns/10ps

module rv32_exec_tb;

    typedef struct packed {
        logic        known;
        logic        valid;
        logic        rd_write;
        logic        killed;
        logic        taken;
        logic        mem_read;
        logic        mem_write;
        logic        zext;
        logic        fence;
        logic [1:0]  bop;
        logic [1:0]  width;
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:0] target;
        logic [31:0] rs2v;
    } stage_t;

    logic        clk, reset, stall, flush, mem_flush, writeback_flush;
    logic        predicted_taken, valid, alu_sub_sra, mem_read, mem_write, mem_zero_extend;
    logic        mem_fence, csr_read, csr_write, csr_src, branch_pc_src, rd_write;
    logic [1:0]  alu_src1, alu_src2, mem_width, csr_write_op, branch_op;
    logic [2:0]  alu_op;
    logic [4:0]  rs1, rs2, rd;
    logic [11:0] csr;
    logic [31:0] pc, rs1_value, rs2_value, imm_value;
    logic        predicted_taken_out, valid_out, mem_read_out, mem_write_out;
    logic        mem_zero_extend_out, mem_fence_out, rd_write_out, wb_valid, wb_rd_write;
    logic [1:0]  mem_width_out, branch_op_out;
    logic [4:0]  rd_out, wb_rd;
    logic [31:0] result, rs2_value_out, branch_pc, wb_value;
    logic [63:0] cycle;

    // Model of the execute output register, the writeback latch and the state around them.
    stage_t      ex;
    stage_t      wb;
    logic [31:0] regs [32];
    logic [31:0] mscratch;
    logic [63:0] edges;
    logic [63:0] retired;
    logic [31:0] seed;
    int          errors;
    logic        checking;

    rv32_exec_top dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // **************************************************
    // Reference model
    // **************************************************

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic alt,
                                              input logic [1:0] s1, input logic [1:0] s2,
                                              input logic [31:0] pc_v, input logic [31:0] r1,
                                              input logic [31:0] r2, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fill;
        a = (s1 == rv32_pkg::src1_rs1) ? r1 : ((s1 == rv32_pkg::src1_pc) ? pc_v : 32'd0);
        b = (s2 == rv32_pkg::src2_rs2) ? r2 : ((s2 == rv32_pkg::src2_imm) ? imm : 32'd4);
        fill = (alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;
        case (op)
            rv32_pkg::alu_add:  return alt ? a + ~b + 32'd1 : a + b;
            rv32_pkg::alu_sll:  return a << b[4:0];
            rv32_pkg::alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            rv32_pkg::alu_sltu: return {31'b0, a < b};
            rv32_pkg::alu_xor:  return a ^ b;
            rv32_pkg::alu_srl:  return (a >> b[4:0]) | fill;
            rv32_pkg::alu_or:   return a | b;
            default:            return a & b;
        endcase
    endfunction

    // The newest writer that is still alive supplies the operand, and x0 never comes from one.
    function automatic logic [31:0] bypassed_operand(input logic [4:0] src,
                                                     input logic [31:0] file_value);
        if (src != 5'd0 && ex.rd_write && ex.rd == src && !mem_flush)
            return ex.result;
        if (src != 5'd0 && wb.rd_write && wb.rd == src && !writeback_flush)
            return wb.result;
        return file_value;
    endfunction

    function automatic logic [31:0] branch_target_of(input logic taken, input logic from_rs1,
                                                     input logic [31:0] pc_v, input logic [31:0] r1,
                                                     input logic [31:0] imm);
        logic [31:0] sum;
        sum = r1 + imm;
        if (taken)
            return pc_v + 32'd4;
        if (from_rs1)
            return {sum[31:1], 1'b0};
        return pc_v + imm;
    endfunction

    function automatic logic [31:0] csr_read_value(input logic [11:0] addr);
        case (addr)
            rv32_pkg::csr_cycle:    return edges[31:0];
            rv32_pkg::csr_cycleh:   return edges[63:32];
            rv32_pkg::csr_instret:  return retired[31:0];
            rv32_pkg::csr_instreth: return retired[63:32];
            rv32_pkg::csr_mscratch: return mscratch;
            default:                return 32'd0;
        endcase
    endfunction

    // Moves to the next rising edge and updates the model from the inputs the DUT samples there.
    task automatic advance_clock();
        stage_t      nxt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] wv;
        @(posedge clk);
        if (reset) begin
            edges = '0;
            retired = '0;
            mscratch = '0;
            ex = '0;
            wb = '0;
        end else begin
            if (!stall) begin
                a = bypassed_operand(rs1, rs1_value);
                b = bypassed_operand(rs2, rs2_value);
                nxt = '0;
                nxt.known = 1'b1;
                nxt.valid = valid && !flush;
                nxt.rd_write = rd_write && !flush;
                nxt.taken = predicted_taken && !flush;
                nxt.mem_read = mem_read && !flush;
                nxt.mem_write = mem_write && !flush;
                nxt.bop = flush ? rv32_pkg::branch_never : branch_op;
                nxt.width = mem_width;
                nxt.zext = mem_zero_extend;
                nxt.fence = mem_fence;
                nxt.rd = rd;
                nxt.rs2v = b;
                nxt.target = branch_target_of(predicted_taken, branch_pc_src, pc, a, imm_value);
                if (csr_read)
                    nxt.result = csr_read_value(csr);
                else
                    nxt.result = alu_model(alu_op, alu_sub_sra, alu_src1, alu_src2, pc, a, b,
                                           imm_value);
                if (valid && csr_write && !flush && csr == rv32_pkg::csr_mscratch) begin
                    wv = csr_src ? {27'b0, imm_value[4:0]} : a;
                    case (csr_write_op)
                        rv32_pkg::csr_rw: mscratch = wv;
                        rv32_pkg::csr_rs: mscratch = mscratch | wv;
                        rv32_pkg::csr_rc: mscratch = mscratch & ~wv;
                        default:          mscratch = mscratch;
                    endcase
                end
                if (wb.valid && !writeback_flush)
                    retired = retired + 64'd1;
                if (wb.rd_write && !wb.killed && !writeback_flush && wb.rd != 5'd0)
                    regs[wb.rd] = wb.result;
                wb = ex;
                wb.killed = mem_flush;
                ex = nxt;
            end
            edges = edges + 64'd1;
        end
    endtask

    // **************************************************
    // Stimulus and checks
    // **************************************************

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic set_controls(input logic st, input logic fl, input logic mf, input logic wf);
        stall <= st;
        flush <= fl;
        mem_flush <= mf;
        writeback_flush <= wf;
    endtask

    task automatic random_instr(input logic [4:0] src_mask, input logic [4:0] rd_base);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  r1;
        logic [4:0]  r2;
        r = next_random();
        s = next_random();
        r1 = r[20:16] & src_mask;
        r2 = r[25:21] & src_mask;
        valid <= 1'b1;
        rs1 <= r1;
        rs2 <= r2;
        rs1_value <= regs[r1];
        rs2_value <= regs[r2];
        rd <= rd_base | (r[30:26] & src_mask);
        rd_write <= 1'b1;
        alu_op <= r[15:13];
        alu_sub_sra <= r[12];
        alu_src1 <= (r[11:10] == 2'd3) ? 2'd0 : r[11:10];
        alu_src2 <= (r[9:8] == 2'd3) ? 2'd1 : r[9:8];
        mem_read <= r[7];
        mem_write <= r[6];
        mem_width <= r[5:4];
        mem_zero_extend <= r[3];
        mem_fence <= r[2];
        predicted_taken <= s[31];
        branch_pc_src <= s[30];
        branch_op <= s[29:28];
        pc <= next_random() & ~32'd3;
        imm_value <= next_random();
        csr_read <= 1'b0;
        csr_write <= 1'b0;
        csr_write_op <= s[27:26];
        csr_src <= s[25];
        csr <= s[11:0];
    endtask

    task automatic csr_access(input logic [1:0] op, input logic imm_src, input logic [11:0] addr,
                              input logic wr);
        random_instr(5'd3, 5'd0);
        csr_read <= 1'b1;
        csr_write <= wr;
        csr_write_op <= op;
        csr_src <= imm_src;
        csr <= addr;
    endtask

    task automatic wait_for_writeback();
        int waited;
        waited = 0;
        valid <= 1'b0;
        rd_write <= 1'b0;
        csr_write <= 1'b0;
        @(negedge clk);
        while (wb_valid !== 1'b1) begin
            if (waited == 10) begin
                $display("wb_valid did not rise within 10 cycles");
                $display("Something failed");
                $fatal(1);
            end
            waited++;
            advance_clock();
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            compare_value("valid_out", valid_out, ex.valid);
            compare_value("rd_write_out", rd_write_out, ex.rd_write);
            compare_value("predicted_taken_out", predicted_taken_out, ex.taken);
            compare_value("mem_read_out", mem_read_out, ex.mem_read);
            compare_value("mem_write_out", mem_write_out, ex.mem_write);
            compare_value("branch_op_out", branch_op_out, ex.bop);
            compare_value("wb_valid", wb_valid, wb.valid);
            compare_value("wb_rd_write", wb_rd_write, wb.rd_write);
            compare_value("cycle", cycle, edges);
            if (ex.known) begin
                compare_value("rd_out", rd_out, ex.rd);
                compare_value("result", result, ex.result);
                compare_value("rs2_value_out", rs2_value_out, ex.rs2v);
                compare_value("branch_pc", branch_pc, ex.target);
                compare_value("mem_width_out", mem_width_out, ex.width);
                compare_value("mem_zero_extend_out", mem_zero_extend_out, ex.zext);
                compare_value("mem_fence_out", mem_fence_out, ex.fence);
            end
            if (wb.known) begin
                compare_value("wb_rd", wb_rd, wb.rd);
                compare_value("wb_value", wb_value, wb.result);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic        prev_mf;
        seed = 32'h42aa_bdd2;
        errors = 0;
        checking = 1'b0;
        regs[0] = 32'd0;
        for (int i = 1; i < 32; i++)
            regs[i] = next_random();
        reset = 1'b1;
        random_instr(5'd15, 5'd16);
        valid <= 1'b0;
        rd_write <= 1'b0;
        set_controls(1'b0, 1'b0, 1'b0, 1'b0);
        repeat (4) advance_clock();
        checking = 1'b1;
        reset <= 1'b0;

        // Independent instructions write x16 to x31 and read only x0 to x15.
        for (int i = 0; i < 40; i++) begin
            random_instr(5'd15, 5'd16);
            advance_clock();
        end
        wait_for_writeback();
        advance_clock();

        // Dense dependencies on x0 to x3, and a killed writer is flushed again in writeback.
        prev_mf = 1'b0;
        for (int i = 0; i < 60; i++) begin
            r = next_random();
            random_instr(5'd3, 5'd0);
            set_controls(1'b0, 1'b0, r[31] & r[30], prev_mf | (r[29] & r[28] & r[27]));
            prev_mf = r[31] & r[30];
            advance_clock();
        end
        valid <= 1'b0;
        rd_write <= 1'b0;
        set_controls(1'b0, 1'b0, 1'b0, prev_mf);
        advance_clock();
        set_controls(1'b0, 1'b0, 1'b0, 1'b0);

        for (int c = 0; c < 12; c++) begin
            random_instr(5'd15, 5'd16);
            predicted_taken <= (c % 3 == 0);
            branch_pc_src <= (c % 3 == 1);
            branch_op <= 2'(c / 3);
            advance_clock();
        end

        for (int c = 0; c < 6; c++) begin
            csr_access(2'(c % 3 + 1), (c >= 3), rv32_pkg::csr_mscratch, 1'b1);
            advance_clock();
        end
        csr_access(2'd0, 1'b0, rv32_pkg::csr_mscratch, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_cycle, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_cycleh, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_instret, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_instreth, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, 12'h7c0, 1'b0);
        advance_clock();

        // Stalled inputs are dropped, so a fresh instruction follows the stall.
        repeat (3) begin
            random_instr(5'd3, 5'd0);
            set_controls(1'b1, 1'b0, 1'b0, 1'b0);
            advance_clock();
        end
        csr_access(2'd0, 1'b0, rv32_pkg::csr_instret, 1'b0);
        set_controls(1'b0, 1'b0, 1'b0, 1'b0);
        advance_clock();

        repeat (3) begin
            random_instr(5'd3, 5'd0);
            set_controls(1'b0, 1'b1, 1'b0, 1'b0);
            advance_clock();
        end
        csr_access(rv32_pkg::csr_rw, 1'b0, rv32_pkg::csr_mscratch, 1'b1);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_mscratch, 1'b0);
        set_controls(1'b0, 1'b0, 1'b0, 1'b0);
        advance_clock();

        // The counters and mscratch read back as zero after a second reset.
        reset <= 1'b1;
        repeat (4) advance_clock();
        reset <= 1'b0;
        csr_access(2'd0, 1'b0, rv32_pkg::csr_instret, 1'b0);
        advance_clock();
        csr_access(2'd0, 1'b0, rv32_pkg::csr_mscratch, 1'b0);
        advance_clock();
        wait_for_writeback();
        advance_clock();

        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* rv32_exec.f */
hdl/rv32_pkg.sv
hdl/rv32_alu.sv
hdl/rv32_csrs.sv
hdl/rv32_execute.sv
hdl/rv32_writeback_latch.sv
hdl/rv32_exec_top.sv
bench/rv32_exec_tb.sv

/* Bender.yml */
package:
  name: rv32_exec

sources:
  - hdl/rv32_pkg.sv
  - hdl/rv32_alu.sv
  - hdl/rv32_csrs.sv
  - hdl/rv32_execute.sv
  - hdl/rv32_writeback_latch.sv
  - hdl/rv32_exec_top.sv
  - target: test
    files:
      - bench/rv32_exec_tb.sv
